//--- verilog/sc64_consts.svh
`ifndef SC64_CONSTS_SVH
`define SC64_CONSTS_SVH

// Work RAM size in 32-bit words
`define SC64_RAM_WORDS 256

// Cycles the bus controller waits before giving up on a device
`define SC64_BUS_TIMEOUT 16

// Number of GPIO pins
`define SC64_GPIO_WIDTH 8

`endif

//--- verilog/sc64_map_pkg.sv
package sc64_map_pkg;

    // Device number lives in the top nibble of the byte address
    localparam int SC64_ID_MSB = 31;
    localparam int SC64_ID_LSB = 28;

    // Values not listed here have no device behind them
    typedef enum logic [3:0] {
        ID_CPU_RAM  = 4'd0,
        ID_CPU_GPIO = 4'd1
    } sc64_device_t;

endpackage

//--- verilog/sc64_bus_pkg.sv
package sc64_bus_pkg;

    // One word request from the CPU side
    typedef struct packed {
        logic [31:0] address;
        logic write;
        logic [3:0] wmask;  // bit 0 enables wdata[7:0]
        logic [31:0] wdata;
    } cpu_bus_req_t;

    // Completion returned to the CPU side
    typedef struct packed {
        logic [31:0] rdata;
        logic error;
    } cpu_bus_rsp_t;

endpackage

//--- verilog/cpu_bus_timer.sv
`timescale 1ns/1ps

`include "sc64_consts.svh"

module cpu_bus_timer (
    input logic clk,
    input logic rst_n,
    input logic start,
    output logic expired
);

    localparam int COUNT_W = $clog2(`SC64_BUS_TIMEOUT + 1);

    logic [COUNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (start) begin
                // The cycle that samples start is the first one of the wait
                count <= COUNT_W'(`SC64_BUS_TIMEOUT - 1);
            end else if (count != '0) begin
                count <= count - 1'b1;
                // Fires on the step to zero
                if (count == COUNT_W'(1)) begin
                    expired <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/cpu_bus_ctrl.sv
`timescale 1ns/1ps

module cpu_bus_ctrl (
    input logic clk,
    input logic rst_n,
    input logic req,
    input sc64_bus_pkg::cpu_bus_req_t req_data,
    output logic busy,
    output logic rsp,
    output sc64_bus_pkg::cpu_bus_rsp_t rsp_data,
    output sc64_bus_pkg::cpu_bus_req_t dev_data,
    output logic ram_req,
    output logic gpio_req,
    input logic ram_ack,
    input logic [31:0] ram_rdata,
    input logic gpio_ack,
    input logic [31:0] gpio_rdata,
    output logic timer_start,
    input logic timer_expired
);

    import sc64_map_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        RESPOND
    } state_t;

    state_t state;
    sc64_device_t req_dev;
    sc64_device_t cur_dev;
    logic dev_ack;
    logic [31:0] dev_rdata;

    assign req_dev = sc64_device_t'(req_data.address[SC64_ID_MSB:SC64_ID_LSB]);
    assign cur_dev = sc64_device_t'(dev_data.address[SC64_ID_MSB:SC64_ID_LSB]);

    // Pick the answer of the device currently being served
    always_comb begin
        case (cur_dev)
            ID_CPU_RAM: begin
                dev_ack = ram_ack;
                dev_rdata = ram_rdata;
            end
            ID_CPU_GPIO: begin
                dev_ack = gpio_ack;
                dev_rdata = gpio_rdata;
            end
            default: begin
                dev_ack = 1'b0;
                dev_rdata = '0;
            end
        endcase
    end

    assign busy = (state != IDLE);
    assign rsp = (state == RESPOND);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            ram_req <= 1'b0;
            gpio_req <= 1'b0;
            timer_start <= 1'b0;
        end else begin
            ram_req <= 1'b0;
            gpio_req <= 1'b0;
            timer_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= WAIT;
                        case (req_dev)
                            ID_CPU_RAM: ram_req <= 1'b1;
                            ID_CPU_GPIO: gpio_req <= 1'b1;
                            // Nobody will answer, let the timer end it
                            default: timer_start <= 1'b1;
                        endcase
                    end
                end
                WAIT: begin
                    if (dev_ack || timer_expired) begin
                        state <= RESPOND;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            dev_data <= req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT) begin
            if (dev_ack) begin
                rsp_data.rdata <= dev_data.write ? 32'd0 : dev_rdata;
                rsp_data.error <= 1'b0;
            end else if (timer_expired) begin
                rsp_data.rdata <= 32'd0;
                rsp_data.error <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/cpu_ram.sv
`timescale 1ns/1ps

`include "sc64_consts.svh"

module cpu_ram (
    input logic clk,
    input logic rst_n,
    input logic req,
    input sc64_bus_pkg::cpu_bus_req_t req_data,
    output logic ack,
    output logic [31:0] rdata
);

    localparam int INDEX_W = $clog2(`SC64_RAM_WORDS);

    logic [31:0] mem [`SC64_RAM_WORDS];
    logic [INDEX_W-1:0] index;

    // Word index from the byte address
    assign index = req_data.address[INDEX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdata <= mem[index];
            if (req_data.write) begin
                for (int i = 0; i < 4; i++) begin
                    if (req_data.wmask[i]) begin
                        mem[index][i*8 +: 8] <= req_data.wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- verilog/cpu_gpio.sv
`timescale 1ns/1ps

`include "sc64_consts.svh"

module cpu_gpio (
    input logic clk,
    input logic rst_n,
    input logic req,
    input sc64_bus_pkg::cpu_bus_req_t req_data,
    output logic ack,
    output logic [31:0] rdata,
    input logic [`SC64_GPIO_WIDTH-1:0] gpio_i,
    output logic [`SC64_GPIO_WIDTH-1:0] gpio_o,
    output logic [`SC64_GPIO_WIDTH-1:0] gpio_oe
);

    localparam int W = `SC64_GPIO_WIDTH;

    logic [W-1:0] gpio_i_meta;
    logic [W-1:0] gpio_i_sync;
    logic [1:0] word;

    assign word = req_data.address[3:2];

    // Two stages before the pins reach the bus
    always_ff @(posedge clk) begin
        gpio_i_meta <= gpio_i;
        gpio_i_sync <= gpio_i_meta;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
            gpio_o <= '0;
            gpio_oe <= '0;
        end else begin
            ack <= req;
            if (req && req_data.write && req_data.wmask[0]) begin
                case (word)
                    2'd0: gpio_o <= req_data.wdata[W-1:0];
                    2'd1: gpio_oe <= req_data.wdata[W-1:0];
                    default: ;  // input and spare words are read-only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (word)
                2'd0: rdata <= {{(32-W){1'b0}}, gpio_o};
                2'd1: rdata <= {{(32-W){1'b0}}, gpio_oe};
                2'd2: rdata <= {{(32-W){1'b0}}, gpio_i_sync};
                default: rdata <= 32'd0;
            endcase
        end
    end

endmodule

//--- verilog/cpu_soc.sv
`timescale 1ns/1ps

`include "sc64_consts.svh"

module cpu_soc (
    input logic clk,
    input logic rst_n,
    input logic req,
    input sc64_bus_pkg::cpu_bus_req_t req_data,
    output logic busy,
    output logic rsp,
    output sc64_bus_pkg::cpu_bus_rsp_t rsp_data,
    input logic [`SC64_GPIO_WIDTH-1:0] gpio_i,
    output logic [`SC64_GPIO_WIDTH-1:0] gpio_o,
    output logic [`SC64_GPIO_WIDTH-1:0] gpio_oe
);

    import sc64_bus_pkg::*;

    cpu_bus_req_t dev_data;
    logic ram_req;
    logic ram_ack;
    logic [31:0] ram_rdata;
    logic gpio_req;
    logic gpio_ack;
    logic [31:0] gpio_rdata;
    logic timer_start;
    logic timer_expired;

    cpu_bus_ctrl cpu_bus_ctrl_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .req_data(req_data),
        .busy(busy),
        .rsp(rsp),
        .rsp_data(rsp_data),
        .dev_data(dev_data),
        .ram_req(ram_req),
        .gpio_req(gpio_req),
        .ram_ack(ram_ack),
        .ram_rdata(ram_rdata),
        .gpio_ack(gpio_ack),
        .gpio_rdata(gpio_rdata),
        .timer_start(timer_start),
        .timer_expired(timer_expired)
    );

    cpu_bus_timer cpu_bus_timer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .start(timer_start),
        .expired(timer_expired)
    );

    cpu_ram cpu_ram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req(ram_req),
        .req_data(dev_data),
        .ack(ram_ack),
        .rdata(ram_rdata)
    );

    cpu_gpio cpu_gpio_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req(gpio_req),
        .req_data(dev_data),
        .ack(gpio_ack),
        .rdata(gpio_rdata),
        .gpio_i(gpio_i),
        .gpio_o(gpio_o),
        .gpio_oe(gpio_oe)
    );

endmodule

//--- testbench/tb_cpu_soc.sv
`timescale 1ns/1ps

`include "sc64_consts.svh"

module tb_cpu_soc;

    import sc64_bus_pkg::*;
    import sc64_map_pkg::*;

    localparam int W = `SC64_GPIO_WIDTH;
    localparam int WAIT_LIMIT = `SC64_BUS_TIMEOUT + 8;
    localparam int POOL_SIZE = 12;

    typedef struct packed {
        cpu_bus_rsp_t rsp;
        int edge_no;
    } expect_t;

    logic clk = 1'b0;
    logic rst_n;
    logic req;
    cpu_bus_req_t req_data;
    logic busy;
    logic rsp;
    cpu_bus_rsp_t rsp_data;
    logic [W-1:0] gpio_i;
    logic [W-1:0] gpio_o;
    logic [W-1:0] gpio_oe;

    // Model state
    logic [31:0] ref_ram [`SC64_RAM_WORDS];
    logic [W-1:0] ref_gpio_o;
    logic [W-1:0] ref_gpio_oe;
    logic [W-1:0] ref_gpio_i;
    logic [31:0] rng_state = 32'hca724f05;

    expect_t expected_q[$];
    expect_t got_exp;
    int cycle = 0;
    int issued = 0;
    int rsp_count = 0;

    cpu_soc i_cpu_soc (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .req_data(req_data),
        .busy(busy),
        .rsp(rsp),
        .rsp_data(rsp_data),
        .gpio_i(gpio_i),
        .gpio_o(gpio_o),
        .gpio_oe(gpio_oe)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic cpu_bus_req_t build_req(input logic [31:0] address, input logic write,
                                               input logic [3:0] wmask, input logic [31:0] wdata);
        cpu_bus_req_t r;
        r.address = address;
        r.write = write;
        r.wmask = wmask;
        r.wdata = wdata;
        return r;
    endfunction

    // Cycles from the req edge to the edge that sees rsp
    function automatic int expected_latency(input logic [31:0] address);
        if (address[31:28] == ID_CPU_RAM || address[31:28] == ID_CPU_GPIO) begin
            return 3;
        end
        return `SC64_BUS_TIMEOUT + 2;
    endfunction

    // Expected response and model update for writes
    function automatic cpu_bus_rsp_t reference_response(input cpu_bus_req_t r);
        cpu_bus_rsp_t res;
        logic [7:0] idx;
        res.rdata = 32'd0;
        res.error = 1'b0;
        idx = r.address[9:2];
        case (r.address[31:28])
            ID_CPU_RAM: begin
                if (r.write) begin
                    for (int i = 0; i < 4; i++) begin
                        if (r.wmask[i]) begin
                            ref_ram[idx][i*8 +: 8] = r.wdata[i*8 +: 8];
                        end
                    end
                end else begin
                    res.rdata = ref_ram[idx];
                end
            end
            ID_CPU_GPIO: begin
                if (r.write) begin
                    if (r.wmask[0] && r.address[3:2] == 2'd0) begin
                        ref_gpio_o = r.wdata[W-1:0];
                    end else if (r.wmask[0] && r.address[3:2] == 2'd1) begin
                        ref_gpio_oe = r.wdata[W-1:0];
                    end
                end else begin
                    case (r.address[3:2])
                        2'd0: res.rdata = {{(32-W){1'b0}}, ref_gpio_o};
                        2'd1: res.rdata = {{(32-W){1'b0}}, ref_gpio_oe};
                        2'd2: res.rdata = {{(32-W){1'b0}}, ref_gpio_i};
                        default: res.rdata = 32'd0;
                    endcase
                end
            end
            default: begin
                res.error = 1'b1;
            end
        endcase
        return res;
    endfunction

    // Response checker taking one expectation per accepted request
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst_n && rsp) begin
            assert (expected_q.size() > 0)
            else stop_on_error($sformatf("Fail at %0t: response with no request open", $time));
            got_exp = expected_q.pop_front();
            assert (cycle == got_exp.edge_no)
            else stop_on_error($sformatf("Fail at %0t: response on edge %0d, expected edge %0d",
                                         $time, cycle, got_exp.edge_no));
            assert (rsp_data === got_exp.rsp)
            else stop_on_error($sformatf("Fail at %0t: rdata %h error %b, expected %h error %b",
                                         $time, rsp_data.rdata, rsp_data.error,
                                         got_exp.rsp.rdata, got_exp.rsp.error));
            rsp_count = rsp_count + 1;
        end
    end

    task automatic issue_request(input cpu_bus_req_t r, input bit poke_busy);
        expect_t e;
        int waited;
        logic [31:0] extra;
        e.rsp = reference_response(r);
        e.edge_no = cycle + 1 + expected_latency(r.address);
        expected_q.push_back(e);
        issued = issued + 1;
        req = 1'b1;
        req_data = r;
        @(posedge clk);
        #1;
        req = 1'b0;
        if (poke_busy) begin
            assert (busy === 1'b1)
            else stop_on_error($sformatf("Fail at %0t: busy low with a request open", $time));
            // Should be dropped by the controller
            extra = next_rand();
            req = 1'b1;
            req_data = build_req({4'hf, extra[27:2], 2'b00}, 1'b0, 4'h0, 32'd0);
            @(posedge clk);
            #1;
            req = 1'b0;
        end
        waited = 0;
        while (rsp_count != issued) begin
            assert (waited < WAIT_LIMIT)
            else stop_on_error($sformatf("No response arrived within %0d cycles of a request",
                                         WAIT_LIMIT));
            @(posedge clk);
            #1;
            waited = waited + 1;
        end
    endtask

    initial begin
        logic [31:0] pool [POOL_SIZE];
        logic [31:0] r;
        logic [31:0] d;
        int k;
        req = 1'b0;
        req_data = '0;
        gpio_i = '0;
        rst_n = 1'b0;
        ref_gpio_o = '0;
        ref_gpio_oe = '0;
        ref_gpio_i = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        assert (busy === 1'b0 && rsp === 1'b0 && gpio_o === '0 && gpio_oe === '0)
        else stop_on_error($sformatf("Fail at %0t: outputs not cleared by reset", $time));

        // Fill a pool of RAM words completely first
        for (int i = 0; i < POOL_SIZE; i++) begin
            r = next_rand();
            pool[i] = {4'd0, r[27:2], 2'b00};
            issue_request(build_req(pool[i], 1'b1, 4'hf, next_rand()), 1'b0);
        end
        for (int i = 0; i < 60; i++) begin
            r = next_rand();
            k = r[7:0] % POOL_SIZE;
            d = next_rand();
            issue_request(build_req(pool[k], 1'b1, r[11:8], d), 1'b0);
            r = next_rand();
            k = r[7:0] % POOL_SIZE;
            issue_request(build_req(pool[k], 1'b0, 4'h0, 32'd0), 1'b0);
        end

        // GPIO output and output-enable words
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            d = next_rand();
            issue_request(build_req({4'd1, r[27:4], 1'b0, r[0], 2'b00}, 1'b1, r[7:4], d), 1'b0);
            assert (gpio_o === ref_gpio_o && gpio_oe === ref_gpio_oe)
            else stop_on_error($sformatf("Fail at %0t: pins o=%h oe=%h, expected o=%h oe=%h",
                                         $time, gpio_o, gpio_oe, ref_gpio_o, ref_gpio_oe));
            issue_request(build_req({4'd1, 24'd0, 4'h0}, 1'b0, 4'h0, 32'd0), 1'b0);
            issue_request(build_req({4'd1, 24'd0, 4'h4}, 1'b0, 4'h0, 32'd0), 1'b0);
        end
        issue_request(build_req({4'd1, 24'd0, 4'hc}, 1'b0, 4'h0, 32'd0), 1'b0);

        // Input pins through the synchronizer
        for (int i = 0; i < 6; i++) begin
            r = next_rand();
            gpio_i = r[W-1:0];
            ref_gpio_i = r[W-1:0];
            repeat (3) @(posedge clk);
            #1;
            issue_request(build_req({4'd1, 24'd0, 4'h8}, 1'b0, 4'h0, 32'd0), 1'b0);
        end

        // Unmapped device numbers and a stray req while busy
        for (int dev = 2; dev < 16; dev++) begin
            r = next_rand();
            d = next_rand();
            issue_request(build_req({dev[3:0], r[27:2], 2'b00}, r[28], r[31:28], d), 1'b1);
        end

        // Give any wrongly accepted request time to answer
        repeat (WAIT_LIMIT) @(posedge clk);
        #1;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/sc64_map_pkg.sv
verilog/sc64_bus_pkg.sv
verilog/cpu_bus_timer.sv
verilog/cpu_bus_ctrl.sv
verilog/cpu_ram.sv
verilog/cpu_gpio.sv
verilog/cpu_soc.sv
testbench/tb_cpu_soc.sv
